// File: source/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

`define ICACHE_WAYS 4
`define ICACHE_SETS 16
`define ICACHE_LINE_WORDS 16

// Address split, 22 + 4 + 4 + 2 byte bits
`define ICACHE_TAG_BITS 22
`define ICACHE_INDEX_BITS 4
`define ICACHE_OFFSET_BITS 4

//////////////////////////////////////////////////
// Memory side
//////////////////////////////////////////////////

// One data strobe per word of the line
`define ICACHE_BURST_LEN `ICACHE_LINE_WORDS

`endif

// File: source/cache_geom_pkg.sv
`include "icache_defs.svh"

package cache_geom_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Address fields
  typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0] set_idx_t;
  typedef logic [`ICACHE_OFFSET_BITS-1:0] word_off_t;

  // Way bookkeeping
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;
  typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

  // Age wraps at the way count
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] age_t;

  // Decoded fetch address, msb first
  typedef struct packed {
    tag_t        tag;
    set_idx_t    set;
    word_off_t   off;
    logic [1:0]  byte_sel;
  } fetch_addr_s;

endpackage

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;
  import cache_geom_pkg::*;

  // Request toward memory; sen is a level held through the burst
  typedef struct packed {
    logic  sen;
    addr_t addr;
  } mem_req_s;

  // Refill sequencer
  typedef enum logic [1:0] {
    rf_idle,
    rf_addr,
    rf_data,
    rf_commit
  } refill_state_e;

endpackage

// File: source/way_store.sv
`include "icache_defs.svh"

module way_store
  import cache_geom_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fetch_addr_s rd_addr,
  input  logic        wr_en,
  input  way_idx_t    wr_way,
  input  set_idx_t    wr_set,
  input  word_off_t   wr_off,
  input  word_t       wr_data,
  input  logic        commit,
  input  tag_t        commit_tag,
  output way_mask_t   hit_mask,
  output way_mask_t   valid_mask,
  output word_t       hit_word
);

  tag_t        tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
  word_t       data_mem [`ICACHE_WAYS][`ICACHE_SETS*`ICACHE_LINE_WORDS];
  way_mask_t   valid [`ICACHE_SETS];
  fetch_addr_s rd_q;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        valid[s] <= '0;
    end
    else if (commit)
    begin
      valid[wr_set][wr_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (commit)
      tag_mem[wr_way][wr_set] <= commit_tag;
    // Refill words land straight in the victim way
    if (wr_en)
      data_mem[wr_way][{wr_set, wr_off}] <= wr_data;
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Address register makes the read synchronous
  always_ff @(posedge clk)
  begin
    rd_q <= rd_addr;
  end

  assign valid_mask = valid[rd_q.set];

  always_comb
  begin
    for (int w = 0; w < `ICACHE_WAYS; w++)
      hit_mask[w] = valid_mask[w] && (tag_mem[w][rd_q.set] == rd_q.tag);
  end

  // Lowest hitting way, zero when nothing hits
  always_comb
  begin
    hit_word = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
    begin
      if (hit_mask[w])
        hit_word = data_mem[w][{rd_q.set, rd_q.off}];
    end
  end

endmodule

// File: source/age_tracker.sv
`include "icache_defs.svh"

module age_tracker
  import cache_geom_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  set_idx_t  set,
  input  way_mask_t valid_mask,
  input  logic      touch,
  input  way_idx_t  touch_way,
  output way_idx_t  victim_way
);

  age_t ages [`ICACHE_SETS][`ICACHE_WAYS];

  // Touched way becomes youngest, the younger ones age by one
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        for (int w = 0; w < `ICACHE_WAYS; w++)
          ages[s][w] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        if (way_idx_t'(w) == touch_way)
          ages[set][w] <= '0;
        else if (ages[set][w] <= ages[set][touch_way])
          ages[set][w] <= ages[set][w] + age_t'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Victim choice
  //////////////////////////////////////////////////

  always_comb
  begin : pick_victim
    logic found;
    found = 1'b0;
    victim_way = '0;
    // Free way first
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!found && !valid_mask[w])
      begin
        victim_way = way_idx_t'(w);
        found = 1'b1;
      end
    end
    // Otherwise the oldest, strict compare keeps the lower index on a tie
    if (!found)
    begin
      for (int w = 1; w < `ICACHE_WAYS; w++)
      begin
        if (ages[set][w] > ages[set][victim_way])
          victim_way = way_idx_t'(w);
      end
    end
  end

endmodule

// File: source/line_refill.sv
`include "icache_defs.svh"

module line_refill
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        refill_start,
  input  fetch_addr_s fill_addr,
  input  way_idx_t    fill_way,
  input  logic        addr_ok,
  input  logic        data_ok,
  input  word_t       sdata,
  output mem_req_s    mem_req,
  output logic        wr_en,
  output way_idx_t    wr_way,
  output set_idx_t    wr_set,
  output word_off_t   wr_off,
  output word_t       wr_data,
  output logic        commit,
  output tag_t        commit_tag,
  output logic        refill_done
);

  refill_state_e state;
  fetch_addr_s   addr_q;
  way_idx_t      way_q;
  word_off_t     cnt;
  logic          last_word;

  assign last_word = (cnt == word_off_t'(`ICACHE_BURST_LEN - 1));

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= rf_idle;
      cnt <= '0;
      refill_done <= 1'b0;
    end
    else
    begin
      refill_done <= (state == rf_commit);
      case (state)
        rf_idle:
          if (refill_start)
          begin
            cnt <= '0;
            state <= rf_addr;
          end
        rf_addr:
          if (addr_ok)
            state <= rf_data;
        rf_data:
          if (data_ok)
          begin
            cnt <= cnt + word_off_t'(1);
            if (last_word)
              state <= rf_commit;
          end
        default:
          state <= rf_idle;
      endcase
    end
  end

  // Target line held for the whole burst
  always_ff @(posedge clk)
  begin
    if (state == rf_idle && refill_start)
    begin
      addr_q <= fill_addr;
      way_q <= fill_way;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    mem_req.sen = (state == rf_addr) || (state == rf_data);
    mem_req.addr = {addr_q.tag, addr_q.set, addr_q.off, 2'b00};
  end

  // Burst wraps from the requested word
  assign wr_en = (state == rf_data) && data_ok;
  assign wr_way = way_q;
  assign wr_set = addr_q.set;
  assign wr_off = addr_q.off + cnt;
  assign wr_data = sdata;

  assign commit = (state == rf_commit);
  assign commit_tag = addr_q.tag;

endmodule

// File: source/fetch_ctrl.sv
`include "icache_defs.svh"

module fetch_ctrl
  import cache_geom_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  input  addr_t       insaddr,
  input  way_mask_t   hit_mask,
  input  word_t       hit_word,
  input  way_idx_t    victim_way,
  input  logic        refill_done,
  output fetch_addr_s rd_addr,
  output logic        touch,
  output way_idx_t    touch_way,
  output logic        refill_start,
  output way_idx_t    fill_way,
  output word_t       ins,
  output logic        ok,
  output logic        miss
);

  typedef enum logic [1:0] {
    st_idle,
    st_compare,
    st_wait_refill,
    st_relookup
  } ctrl_state_e;

  ctrl_state_e state;
  ctrl_state_e next_state;
  fetch_addr_s addr_q;
  logic        take;
  logic        hit;

  // Request still held while ok is out is the one just answered
  assign take = (state == st_idle) && req && !ok;
  assign hit = |hit_mask;

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:
        if (take)
          next_state = st_compare;
      st_compare:
        next_state = hit ? st_idle : st_wait_refill;
      st_wait_refill:
        if (refill_done)
          next_state = st_relookup;
      default:
        next_state = st_compare;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= st_idle;
      ok <= 1'b0;
    end
    else
    begin
      state <= next_state;
      ok <= (state == st_compare) && hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      addr_q <= insaddr;
    if (state == st_compare && hit)
      ins <= hit_word;
  end

  //////////////////////////////////////////////////
  // Lookup and refill control
  //////////////////////////////////////////////////

  // Incoming address goes to the store at once so the read overlaps the latch
  assign rd_addr = (state == st_idle) ? fetch_addr_s'(insaddr) : addr_q;

  always_comb
  begin
    touch_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
    begin
      if (hit_mask[w])
        touch_way = way_idx_t'(w);
    end
  end

  assign touch = (state == st_compare) && hit;
  assign refill_start = (state == st_compare) && !hit;
  assign fill_way = victim_way;
  assign miss = (state == st_wait_refill);

endmodule

// File: source/icache_top.sv
module icache_top
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  addr_t    insaddr,
  output word_t    ins,
  output logic     ok,
  output logic     miss,
  output mem_req_s mem_req,
  input  logic     addr_ok,
  input  logic     data_ok,
  input  word_t    sdata
);

  fetch_addr_s rd_addr;
  way_mask_t   hit_mask;
  way_mask_t   valid_mask;
  word_t       hit_word;
  way_idx_t    victim_way;
  logic        touch;
  way_idx_t    touch_way;
  logic        refill_start;
  way_idx_t    fill_way;
  logic        refill_done;

  // Store write port
  logic        wr_en;
  way_idx_t    wr_way;
  set_idx_t    wr_set;
  word_off_t   wr_off;
  word_t       wr_data;
  logic        commit;
  tag_t        commit_tag;

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .insaddr      (insaddr),
    .hit_mask     (hit_mask),
    .hit_word     (hit_word),
    .victim_way   (victim_way),
    .refill_done  (refill_done),
    .rd_addr      (rd_addr),
    .touch        (touch),
    .touch_way    (touch_way),
    .refill_start (refill_start),
    .fill_way     (fill_way),
    .ins          (ins),
    .ok           (ok),
    .miss         (miss)
  );

  way_store u_store (
    .clk        (clk),
    .rst        (rst),
    .rd_addr    (rd_addr),
    .wr_en      (wr_en),
    .wr_way     (wr_way),
    .wr_set     (wr_set),
    .wr_off     (wr_off),
    .wr_data    (wr_data),
    .commit     (commit),
    .commit_tag (commit_tag),
    .hit_mask   (hit_mask),
    .valid_mask (valid_mask),
    .hit_word   (hit_word)
  );

  // Ages follow the set under lookup
  age_tracker u_ages (
    .clk        (clk),
    .rst        (rst),
    .set        (rd_addr.set),
    .valid_mask (valid_mask),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim_way (victim_way)
  );

  line_refill u_refill (
    .clk          (clk),
    .rst          (rst),
    .refill_start (refill_start),
    .fill_addr    (rd_addr),
    .fill_way     (fill_way),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .sdata        (sdata),
    .mem_req      (mem_req),
    .wr_en        (wr_en),
    .wr_way       (wr_way),
    .wr_set       (wr_set),
    .wr_off       (wr_off),
    .wr_data      (wr_data),
    .commit       (commit),
    .commit_tag   (commit_tag),
    .refill_done  (refill_done)
  );

endmodule

// File: bench/mem_model.sv
`include "icache_defs.svh"

module mem_model
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_req_s mem_req,
  output logic     addr_ok,
  output logic     data_ok,
  output word_t    sdata
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {
    m_idle,
    m_accept,
    m_data,
    m_drain
  } phase_e;

  initial
  begin : respond
    integer    seed;
    phase_e    phase;
    addr_t     base;
    int        sent;
    word_off_t off;
    seed = 70;
    phase = m_idle;
    base = '0;
    sent = 0;
    addr_ok <= 1'b0;
    data_ok <= 1'b0;
    sdata <= '0;
    forever
    begin
      @(posedge clk or posedge rst);
      addr_ok <= 1'b0;
      data_ok <= 1'b0;
      if (rst)
        phase = m_idle;
      else
      begin
        case (phase)
          m_idle:
            if (mem_req.sen)
            begin
              base = mem_req.addr;
              phase = m_accept;
            end
          m_accept:
          begin
            addr_ok <= 1'b1;
            sent = 0;
            phase = m_data;
          end
          m_data:
            // Roughly one cycle in four stalls
            if (($random(seed) & 3) != 0)
            begin
              off = base[5:2] + word_off_t'(sent);
              sdata <= {base[31:6], off, 2'b00} ^ 32'h5A5A_0000;
              data_ok <= 1'b1;
              sent++;
              if (sent == `ICACHE_BURST_LEN)
                phase = m_drain;
            end
          default:
            // sen falls once the last word is taken
            if (!mem_req.sen)
              phase = m_idle;
        endcase
      end
    end
  end

endmodule

// File: bench/icache_tb.sv
`include "icache_defs.svh"

module icache_tb
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 22;
  localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS + 10;

  logic     clk;
  logic     rst;
  logic     req;
  addr_t    insaddr;
  word_t    ins;
  logic     ok;
  logic     miss;
  mem_req_s mem_req;
  logic     addr_ok;
  logic     data_ok;
  word_t    sdata;

  int errors;
  int checks;
  int cycle_count = 0;

  string test_name [NUM_TESTS];
  addr_t test_addr [NUM_TESTS];
  word_t test_word [NUM_TESTS];

  // Reference cache state
  bit   ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
  tag_t ref_tag [`ICACHE_SETS][`ICACHE_WAYS];
  age_t ref_age [`ICACHE_SETS][`ICACHE_WAYS];

  icache_top UUT (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .insaddr (insaddr),
    .ins     (ins),
    .ok      (ok),
    .miss    (miss),
    .mem_req (mem_req),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  mem_model u_mem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the cache gave no answer within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic set_entry(input int idx, input string name, input addr_t addr,
                           input word_t data);
    test_name[idx] = name;
    test_addr[idx] = addr;
    test_word[idx] = data;
  endtask

  // Set 3 takes tags 0x40 to 0x140, word = address ^ 0x5A5A0000
  task automatic load_table();
    set_entry(0, "cold miss", 32'h0001_00D4, 32'h5A5B_00D4);
    set_entry(1, "repeat hit", 32'h0001_00D4, 32'h5A5B_00D4);
    set_entry(2, "word 0 before wrap", 32'h0001_00C0, 32'h5A5B_00C0);
    set_entry(3, "word 15", 32'h0001_00FC, 32'h5A5B_00FC);
    set_entry(4, "word 4", 32'h0001_00D0, 32'h5A5B_00D0);
    set_entry(5, "fill way B", 32'h0002_00E8, 32'h5A58_00E8);
    set_entry(6, "fill way C", 32'h0003_00C4, 32'h5A59_00C4);
    set_entry(7, "fill way D", 32'h0004_00F0, 32'h5A5E_00F0);
    set_entry(8, "hit B", 32'h0002_00E8, 32'h5A58_00E8);
    set_entry(9, "hit A", 32'h0001_00D4, 32'h5A5B_00D4);
    set_entry(10, "hit D", 32'h0004_00F0, 32'h5A5E_00F0);
    set_entry(11, "hit C", 32'h0003_00C4, 32'h5A59_00C4);
    set_entry(12, "fifth tag E", 32'h0005_00C8, 32'h5A5F_00C8);
    set_entry(13, "refetch B", 32'h0002_00E8, 32'h5A58_00E8);
    set_entry(14, "C after evict", 32'h0003_00C4, 32'h5A59_00C4);
    set_entry(15, "D after evict", 32'h0004_00F0, 32'h5A5E_00F0);
    set_entry(16, "E after evict", 32'h0005_00C8, 32'h5A5F_00C8);
    set_entry(17, "refetch A", 32'h0001_00D4, 32'h5A5B_00D4);
    set_entry(18, "set 15 last word", 32'h0000_03FC, 32'h5A5A_03FC);
    set_entry(19, "set 15 word 0", 32'h0000_03C0, 32'h5A5A_03C0);
    set_entry(20, "high tag", 32'h8000_0000, 32'hDA5A_0000);
    set_entry(21, "high tag word 7", 32'h8000_001C, 32'hDA5A_001C);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int find_way(input set_idx_t set, input tag_t tag);
    int way;
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (way < 0 && ref_valid[set][w] && ref_tag[set][w] == tag)
        way = w;
    return way;
  endfunction

  // First free way, else the oldest with the lower index on a tie
  function automatic int choose_victim(input set_idx_t set);
    int way;
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (way < 0 && !ref_valid[set][w])
        way = w;
    if (way < 0)
    begin
      way = 0;
      for (int w = 1; w < `ICACHE_WAYS; w++)
        if (ref_age[set][w] > ref_age[set][way])
          way = w;
    end
    return way;
  endfunction

  function automatic void update_ages(input set_idx_t set, input int way);
    age_t pivot;
    pivot = ref_age[set][way];
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (w == way)
        ref_age[set][w] = '0;
      else if (ref_age[set][w] <= pivot)
        ref_age[set][w] = ref_age[set][w] + 2'd1;
    end
  endfunction

  // Returns 1 when the fetch must go to memory
  function automatic bit predict_fetch(input addr_t addr);
    fetch_addr_s f;
    int          way;
    bit          will_miss;
    f = fetch_addr_s'(addr);
    way = find_way(f.set, f.tag);
    will_miss = (way < 0);
    if (will_miss)
    begin
      way = choose_victim(f.set);
      ref_valid[f.set][way] = 1'b1;
      ref_tag[f.set][way] = f.tag;
    end
    update_ages(f.set, way);
    return will_miss;
  endfunction

  //////////////////////////////////////////////////
  // Checks and fetch sequence
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic run_fetch(input int idx);
    bit    exp_miss;
    bit    sen_seen;
    bit    miss_seen;
    addr_t sen_addr;
    int    latency;
    int    words;
    exp_miss = predict_fetch(test_addr[idx]);
    sen_seen = 1'b0;
    miss_seen = 1'b0;
    sen_addr = '0;
    latency = 0;
    words = 0;
    req <= 1'b1;
    insaddr <= test_addr[idx];
    // Edge where the cache samples req
    @(posedge clk);
    while (!ok)
    begin
      @(posedge clk);
      latency++;
      if (mem_req.sen && !sen_seen)
      begin
        sen_seen = 1'b1;
        sen_addr = mem_req.addr;
      end
      if (miss)
        miss_seen = 1'b1;
      if (data_ok)
        words++;
    end
    req <= 1'b0;
    check_value({test_name[idx], " data"}, test_word[idx], ins);
    check_value({test_name[idx], " sen"}, 32'(exp_miss), 32'(sen_seen));
    check_value({test_name[idx], " miss level"}, 32'(exp_miss), 32'(miss_seen));
    if (exp_miss)
    begin
      check_value({test_name[idx], " burst address"}, {test_addr[idx][31:2], 2'b00},
                  sen_addr);
      check_value({test_name[idx], " burst words"}, `ICACHE_BURST_LEN, words);
    end
    else
      check_value({test_name[idx], " hit latency"}, 2, latency);
    @(posedge clk);
  endtask

  initial
  begin
    rst <= 1'b1;
    req <= 1'b0;
    insaddr <= '0;
    errors = 0;
    checks = 0;
    for (int s = 0; s < `ICACHE_SETS; s++)
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w] = '0;
        ref_age[s][w] = '0;
      end
    load_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < NUM_TESTS; i++)
      run_fetch(i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+source
source/cache_geom_pkg.sv
source/mem_bus_pkg.sv
source/way_store.sv
source/age_tracker.sv
source/line_refill.sv
source/fetch_ctrl.sv
source/icache_top.sv
bench/mem_model.sv
bench/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: simulate clean

# Build, run, and fail unless the pass line shows up
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
